/* dv/vec_ex_patterns.hex */
// writeback: 0000_0D00 byte_en(lane3..lane0 nibbles) data_lane0..lane3 0 0
// execute: 1 op sew vs1 vs2 vd flags{uns,imm,scalar,sext} {mask_en,0,uop}, imm, rdat1, exp_lane0..3, {lane_mask,is_mask_res}
// add against zero immediate straight after reset
10203140 00000000 00000000 00000000 00000000 00000000 00000000 000000F0
// writebacks v2, v3, partial v4, v0
00000200 0000FFFF 01020304 10203040 7F80FF00 00010002 00000000 00000000
00000300 0000FFFF 01010101 00000010 01800001 FFFFFFFF 00000000 00000000
00000400 00000C3F AAAAAAAA AAAAAAAA AAAAAAAA AAAAAAAA 00000000 00000000
00000000 0000FFFF 0000A596 00000000 00000000 00000000 00000000 00000000
// add sew32, add sew8, sub sew16
10232500 00000000 00000000 02030405 10203050 8100FF01 00010001 000000F0
10032500 00000000 00000000 02030405 10203050 8000FF01 FF00FF01 000000F0
11132500 00000000 00000000 00010203 10203030 7E00FEFF 00020003 000000F0
// and sew32 with partial v4, or sew8, xor sew16
12242500 00000000 00000000 00020200 00002000 2A800000 00000000 000000F0
13043600 00000000 00000000 ABABABAB 0000AABA ABAA0001 FFFFFFFF 000000F0
14132700 00000000 00000000 00030205 10203050 7E00FF01 FFFEFFFD 000000F0
// sign-extended imm, zero-extended imm, scalar sew32
10002150 0000001F 00000000 00010203 0F1F2F3F 7E7FFEFF FF00FF01 000000F0
10102140 0000001F 00000000 01210323 103F305F 7F9FFF1F 00200021 000000F0
10203120 00000000 80000001 81010102 80000011 81800002 80000000 000000F0
// min sew8 signed and unsigned, max sew16 signed and unsigned
15032100 00000000 00000000 01010101 00000010 0180FF00 FFFFFFFF 000000F0
15032180 00000000 00000000 01010101 00000010 01800000 00010002 000000F0
16132100 00000000 00000000 01020304 10203040 7F800001 00010002 000000F0
16132180 00000000 00000000 01020304 10203040 7F80FF00 FFFFFFFF 000000F0
// masked add uop0, uop1, unmasked uop2
10232508 00000000 00000000 02030405 10203050 8100FF01 00010001 00000060
10232509 00000000 00000000 02030405 10203050 8100FF01 00010001 00000090
10232502 00000000 00000000 02030405 10203050 8100FF01 00010001 000000F0
// seq, masked sne, masked slt, unsigned slt
17022300 00000000 00000000 0000000F 0000000F 0000000F 0000000F 000000F1
18032309 00000000 00000000 00000090 00000090 00000090 00000090 000000F1
1903230A 00000000 00000000 00000400 00000400 00000400 00000400 000000F1
19032383 00000000 00000000 0000C000 0000C000 0000C000 0000C000 000000F1
// redsum unmasked and masked
1A220400 00000000 00000000 90A43246 00000000 00000000 00000000 00000010
1A220408 00000000 00000000 8FA12F40 00000000 00000000 00000000 00000010
// end of records
F0000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

/* tb.f */
common/vec_types_pkg.sv
common/vec_ctrl_pkg.sv
rtl/vec_bank.sv
rtl/vec_operand_sel.sv
vfu/vec_lane_alu.sv
rtl/vec_result_merge.sv
rtl/vec_ex_unit.sv
dv/vec_ex_tb.sv

/* Makefile */
# Verilator flow for the vector execute stage

VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= vec_ex_tb
RTL_TOP   ?= vec_ex_unit
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/vec_ex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_ex_tb;
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    localparam int LANES     = 4;
    localparam int VREGS     = 8;
    localparam int REC_WORDS = 8;
    localparam int MEM_WORDS = 512;
    localparam int TIMEOUT   = 20;

    logic                     CLK;
    logic                     rst;
    logic                     ex_valid;
    vcontrol_t                vctrl;
    word_t                    rdat1;
    word_t                    rdat2;
    vwb_ctrl_t                wb_ctrl;
    word_t [LANES-1:0]        wb_data;
    byte_en_t [LANES-1:0]     wb_byte_en;
    logic                     exmem_valid;
    vexmem_ctrl_t             exmem_ctrl;
    word_t [LANES-1:0]        exmem_res;
    word_t [LANES-1:0]        exmem_vs1;

    logic [31:0]              pat_mem [MEM_WORDS];
    // register contents as the writebacks leave them
    word_t [LANES-1:0]        vreg_model [VREGS];
    word_t [LANES-1:0]        exp_res_q [$];
    word_t [LANES-1:0]        exp_vs1_q [$];
    vexmem_ctrl_t             exp_ctrl_q [$];
    int                       issue_q [$];
    int                       cyc;
    int                       res_errs;
    int                       ctrl_errs;
    int                       other_errs;

    vec_ex_unit #(
        .NUM_LANES(LANES),
        .NUM_VREGS(VREGS)
    ) DUT (
        .CLK         (CLK),
        .rst         (rst),
        .ex_valid    (ex_valid),
        .vctrl       (vctrl),
        .rdat1       (rdat1),
        .rdat2       (rdat2),
        .wb_ctrl     (wb_ctrl),
        .wb_data     (wb_data),
        .wb_byte_en  (wb_byte_en),
        .exmem_valid (exmem_valid),
        .exmem_ctrl  (exmem_ctrl),
        .exmem_res   (exmem_res),
        .exmem_vs1   (exmem_vs1)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    task automatic check_res(input string name, input int lane, input word_t exp,
                             input word_t act);
        if (act !== exp) begin
            res_errs++;
            $display("FAILED %s[%0d] expected %08h got %08h", name, lane, exp, act);
        end
    endtask

    task automatic check_ctrl(input vexmem_ctrl_t exp, input vexmem_ctrl_t act);
        if (act !== exp) begin
            ctrl_errs++;
            $display("FAILED exmem_ctrl expected %03h got %03h", exp, act);
        end
    endtask

    // operand B of one lane: immediate, scalar or the vs1 register
    function automatic word_t expected_opb(input vsew_t sew, input valuop_t op,
                                           input logic use_imm, input logic use_scalar,
                                           input logic sx, input logic [4:0] imm,
                                           input word_t scalar, input word_t bank_word);
        int          ew;
        logic [63:0] emask;
        logic        imm_sx;
        word_t       ext;
        word_t       w;
        ew     = (sew == SEW8) ? 8 : (sew == SEW16) ? 16 : 32;
        emask  = (64'd1 << ew) - 64'd1;
        imm_sx = sx || op == VALU_SEQ || op == VALU_SNE || op == VALU_SLT;
        if (use_imm) begin
            // one extended element copied into every element slot
            ext = {{27{imm_sx & imm[4]}}, imm} & emask[31:0];
            w   = '0;
            for (int i = 0; i < 32 / ew; i++) begin
                w = w | (ext << (i * ew));
            end
        end else if (use_scalar) begin
            ext = scalar & emask[31:0];
            if (sx && scalar[ew-1]) begin
                ext = ext | ~emask[31:0];
            end
            w = ext;
        end else begin
            w = bank_word;
        end
        return w;
    endfunction

    // outputs are stable at the falling edge
    always @(negedge CLK) begin
        word_t [LANES-1:0] exp_res;
        word_t [LANES-1:0] exp_vs1;
        vexmem_ctrl_t      exp_ctrl;
        int                issued;
        if (!rst) begin
            // strobe is high during this cycle
            if (ex_valid) begin
                issue_q.push_back(cyc);
            end
            if (exmem_valid) begin
                if (exp_ctrl_q.size() == 0) begin
                    other_errs++;
                    $display("result arrived while no operation was outstanding");
                end else begin
                    exp_res  = exp_res_q.pop_front();
                    exp_vs1  = exp_vs1_q.pop_front();
                    exp_ctrl = exp_ctrl_q.pop_front();
                    issued   = issue_q.pop_front();
                    if (cyc - issued != 2) begin
                        other_errs++;
                        $display("result came %0d cycles after its strobe instead of 2",
                                 cyc - issued);
                    end
                    for (int k = 0; k < LANES; k++) begin
                        check_res("exmem_res", k, exp_res[k], exmem_res[k]);
                        check_res("exmem_vs1", k, exp_vs1[k], exmem_vs1[k]);
                    end
                    check_ctrl(exp_ctrl, exmem_ctrl);
                end
            end
        end
    end

    initial begin
        int                base;
        int                gap;
        int                t;
        logic [31:0]       w0;
        word_t [LANES-1:0] exp_res;
        word_t [LANES-1:0] exp_vs1;
        vexmem_ctrl_t      exp_ctrl;

        cyc        = 0;
        res_errs   = 0;
        ctrl_errs  = 0;
        other_errs = 0;
        rst        = 1'b1;
        ex_valid   = 1'b0;
        vctrl      = '0;
        rdat1      = '0;
        rdat2      = '0;
        wb_ctrl    = '0;
        wb_data    = '0;
        wb_byte_en = '0;
        for (int v = 0; v < VREGS; v++) begin
            vreg_model[v] = '0;
        end
        void'($urandom(32'h0658_a23b));
        $readmemh("dv/vec_ex_patterns.hex", pat_mem);

        repeat (4) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        if (exmem_valid !== 1'b0) begin
            other_errs++;
            $display("exmem_valid is not low after reset");
        end

        for (int r = 0; r < MEM_WORDS / REC_WORDS; r++) begin
            base = r * REC_WORDS;
            w0   = pat_mem[base];
            if (w0[31:28] != 4'h0 && w0[31:28] != 4'h1) begin
                break;
            end
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge CLK);
                ex_valid   <= 1'b0;
                wb_ctrl.en <= 1'b0;
            end
            @(posedge CLK);
            if (w0[31:28] == 4'h0) begin
                ex_valid   <= 1'b0;
                wb_ctrl.en <= 1'b1;
                wb_ctrl.vd <= w0[10:8];
                for (int k = 0; k < LANES; k++) begin
                    wb_byte_en[k] <= pat_mem[base+1][4*k +: 4];
                    wb_data[k]    <= pat_mem[base+2+k];
                    for (int b = 0; b < 4; b++) begin
                        if (pat_mem[base+1][4*k+b]) begin
                            vreg_model[w0[10:8]][k][8*b +: 8] = pat_mem[base+2+k][8*b +: 8];
                        end
                    end
                end
            end else begin
                wb_ctrl.en        <= 1'b0;
                ex_valid          <= 1'b1;
                vctrl.valuop      <= valuop_t'(w0[27:24]);
                vctrl.vsew        <= vsew_t'(w0[21:20]);
                vctrl.vs1_sel     <= w0[18:16];
                vctrl.vs2_sel     <= w0[14:12];
                vctrl.vd_sel      <= w0[10:8];
                vctrl.opunsigned  <= w0[7];
                vctrl.use_imm     <= w0[6];
                vctrl.use_scalar  <= w0[5];
                vctrl.sign_ext    <= w0[4];
                vctrl.mask_en     <= w0[3];
                vctrl.uop_num     <= w0[1:0];
                vctrl.imm         <= pat_mem[base+1][4:0];
                rdat1             <= pat_mem[base+2];
                for (int k = 0; k < LANES; k++) begin
                    exp_res[k] = pat_mem[base+3+k];
                    exp_vs1[k] = expected_opb(vsew_t'(w0[21:20]), valuop_t'(w0[27:24]),
                                              w0[6], w0[5], w0[4], pat_mem[base+1][4:0],
                                              pat_mem[base+2], vreg_model[w0[18:16]][k]);
                end
                exp_ctrl.vd_sel      = w0[10:8];
                exp_ctrl.uop_num     = w0[1:0];
                exp_ctrl.lane_mask   = pat_mem[base+7][7:4];
                exp_ctrl.is_mask_res = pat_mem[base+7][0];
                exp_res_q.push_back(exp_res);
                exp_vs1_q.push_back(exp_vs1);
                exp_ctrl_q.push_back(exp_ctrl);
            end
        end
        @(posedge CLK);
        ex_valid   <= 1'b0;
        wb_ctrl.en <= 1'b0;

        // drain whatever is still in flight
        t = 0;
        while (exp_ctrl_q.size() != 0 && t < TIMEOUT) begin
            @(posedge CLK);
            t++;
        end
        if (exp_ctrl_q.size() != 0) begin
            other_errs++;
            $display("timed out waiting for exmem_valid, %0d results missing",
                     exp_ctrl_q.size());
        end
        @(negedge CLK);

        $display("errors: res=%0d ctrl=%0d other=%0d", res_errs, ctrl_errs, other_errs);
        if (res_errs + ctrl_errs + other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/vec_ex_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_ex_unit #(
    parameter int NUM_LANES = 4,
    parameter int NUM_VREGS = 8
) (
    input  logic                                       CLK,
    input  logic                                       rst,
    input  logic                                       ex_valid,
    input  vec_ctrl_pkg::vcontrol_t                    vctrl,
    input  vec_types_pkg::word_t                       rdat1,
    input  vec_types_pkg::word_t                       rdat2,
    input  vec_ctrl_pkg::vwb_ctrl_t                    wb_ctrl,
    input  vec_types_pkg::word_t [NUM_LANES-1:0]       wb_data,
    input  vec_types_pkg::byte_en_t [NUM_LANES-1:0]    wb_byte_en,
    output logic                                       exmem_valid,
    output vec_ctrl_pkg::vexmem_ctrl_t                 exmem_ctrl,
    output vec_types_pkg::word_t [NUM_LANES-1:0]       exmem_res,
    output vec_types_pkg::word_t [NUM_LANES-1:0]       exmem_vs1
);
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    word_t [NUM_LANES-1:0]   bank_src1;
    word_t [NUM_LANES-1:0]   bank_src2;
    word_t [NUM_LANES-1:0]   v0_words;
    logic                    s1_valid;
    vcontrol_t               s1_ctrl;
    word_t [NUM_LANES-1:0]   op_a;
    word_t [NUM_LANES-1:0]   op_b;
    logic [4*NUM_LANES-1:0]  s1_v0;
    word_t [NUM_LANES-1:0]   lane_res;

    // one bank slice per lane, all share the register selects
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_bank
        vec_bank #(
            .NUM_VREGS(NUM_VREGS)
        ) u_bank (
            .CLK      (CLK),
            .rst      (rst),
            .vs1      (vctrl.vs1_sel),
            .vs2      (vctrl.vs2_sel),
            .vw       (wb_ctrl.vd),
            .wen      (wb_ctrl.en),
            .byte_wen (wb_byte_en[k]),
            .wdata    (wb_data[k]),
            .vdat1    (bank_src1[k]),
            .vdat2    (bank_src2[k]),
            .v0       (v0_words[k])
        );
    end

    vec_operand_sel #(
        .NUM_LANES(NUM_LANES)
    ) u_operand_sel (
        .CLK       (CLK),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .vctrl     (vctrl),
        .rdat1     (rdat1),
        .rdat2     (rdat2),
        .bank_src1 (bank_src1),
        .bank_src2 (bank_src2),
        .v0_words  (v0_words),
        .s1_valid  (s1_valid),
        .s1_ctrl   (s1_ctrl),
        .opA       (op_a),
        .opB       (op_b),
        .s1_v0     (s1_v0)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        vec_lane_alu u_alu (
            .opA        (op_a[k]),
            .opB        (op_b[k]),
            .vsew       (s1_ctrl.vsew),
            .valuop     (s1_ctrl.valuop),
            .opunsigned (s1_ctrl.opunsigned),
            .res        (lane_res[k])
        );
    end

    vec_result_merge #(
        .NUM_LANES(NUM_LANES)
    ) u_merge (
        .CLK         (CLK),
        .rst         (rst),
        .s1_valid    (s1_valid),
        .s1_ctrl     (s1_ctrl),
        .lane_res    (lane_res),
        .opB         (op_b),
        .s1_v0       (s1_v0),
        .exmem_valid (exmem_valid),
        .exmem_ctrl  (exmem_ctrl),
        .exmem_res   (exmem_res),
        .exmem_vs1   (exmem_vs1)
    );

endmodule

`default_nettype wire

/* rtl/vec_result_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_result_merge #(
    parameter int NUM_LANES = 4
) (
    input  logic                                     CLK,
    input  logic                                     rst,
    input  logic                                     s1_valid,
    input  vec_ctrl_pkg::vcontrol_t                  s1_ctrl,
    input  vec_types_pkg::word_t [NUM_LANES-1:0]     lane_res,
    input  vec_types_pkg::word_t [NUM_LANES-1:0]     opB,
    input  logic [4*NUM_LANES-1:0]                   s1_v0,
    output logic                                     exmem_valid,
    output vec_ctrl_pkg::vexmem_ctrl_t               exmem_ctrl,
    output vec_types_pkg::word_t [NUM_LANES-1:0]     exmem_res,
    output vec_types_pkg::word_t [NUM_LANES-1:0]     exmem_vs1
);
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    logic [NUM_LANES-1:0]  lane_act;
    logic                  is_cmp;
    logic                  is_red;
    word_t                 mskset_word;
    word_t                 red_sum;
    word_t [NUM_LANES-1:0] nxt_res;
    vexmem_ctrl_t          nxt_ctrl;

    assign is_cmp = s1_ctrl.valuop == VALU_SEQ || s1_ctrl.valuop == VALU_SNE ||
                    s1_ctrl.valuop == VALU_SLT;
    assign is_red = s1_ctrl.valuop == VALU_REDSUM;

    // v0 bit for lane k of this micro-op
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_act[k] = !s1_ctrl.mask_en || s1_v0[s1_ctrl.uop_num * NUM_LANES + k];
        end
    end

    // pack compare bits, inactive lanes stay 0
    always_comb begin
        mskset_word = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            mskset_word[s1_ctrl.uop_num * NUM_LANES + k] = lane_act[k] & lane_res[k][0];
        end
    end

    always_comb begin
        red_sum = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (lane_act[k]) begin
                red_sum = red_sum + opB[k];
            end
        end
    end

    always_comb begin
        nxt_ctrl.vd_sel      = s1_ctrl.vd_sel;
        nxt_ctrl.uop_num     = s1_ctrl.uop_num;
        nxt_ctrl.is_mask_res = is_cmp;
        nxt_ctrl.lane_mask   = lane_act;
        for (int k = 0; k < NUM_LANES; k++) begin
            nxt_res[k] = lane_res[k];
        end
        if (is_cmp) begin
            nxt_ctrl.lane_mask = '1;
            for (int k = 0; k < NUM_LANES; k++) begin
                nxt_res[k] = mskset_word;
            end
        end else if (is_red) begin
            // sum lands in lane 0 only
            nxt_ctrl.lane_mask = 4'b0001;
            for (int k = 0; k < NUM_LANES; k++) begin
                nxt_res[k] = (k == 0) ? red_sum : '0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            exmem_valid <= 1'b0;
        end else begin
            exmem_valid <= s1_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (s1_valid) begin
            exmem_ctrl <= nxt_ctrl;
            exmem_res  <= nxt_res;
            exmem_vs1  <= opB;
        end
    end

endmodule

`default_nettype wire

/* vfu/vec_lane_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_lane_alu (
    input  vec_types_pkg::word_t   opA,
    input  vec_types_pkg::word_t   opB,
    input  vec_types_pkg::vsew_t   vsew,
    input  vec_ctrl_pkg::valuop_t  valuop,
    input  logic                   opunsigned,
    output vec_types_pkg::word_t   res
);
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    elem_word_u a_v;
    elem_word_u b_v;
    elem_word_u r_v;
    logic       is_cmp;

    // widen one element by one bit so signed and unsigned compares share logic
    function automatic logic signed [32:0] ext_elem(input word_t x, input vsew_t sew,
                                                    input logic uns);
        logic top;
        case (sew)
            SEW8: begin
                top = uns ? 1'b0 : x[7];
                return {{25{top}}, x[7:0]};
            end
            SEW16: begin
                top = uns ? 1'b0 : x[15];
                return {{17{top}}, x[15:0]};
            end
            default: begin
                top = uns ? 1'b0 : x[31];
                return {top, x};
            end
        endcase
    endfunction

    // caller keeps only the element-width low bits
    function automatic word_t elem_op(input logic signed [32:0] a,
                                      input logic signed [32:0] b, input valuop_t op);
        word_t r;
        r = '0;
        case (op)
            VALU_ADD: r = a[31:0] + b[31:0];
            VALU_SUB: r = a[31:0] - b[31:0];
            VALU_AND: r = a[31:0] & b[31:0];
            VALU_OR:  r = a[31:0] | b[31:0];
            VALU_XOR: r = a[31:0] ^ b[31:0];
            VALU_MIN: r = (a < b) ? a[31:0] : b[31:0];
            VALU_MAX: r = (a > b) ? a[31:0] : b[31:0];
            VALU_SEQ: r = {31'b0, a == b};
            VALU_SNE: r = {31'b0, a != b};
            VALU_SLT: r = {31'b0, a < b};
            default:  r = b[31:0];
        endcase
        return r;
    endfunction

    assign a_v = opA;
    assign b_v = opB;

    assign is_cmp = valuop == VALU_SEQ || valuop == VALU_SNE || valuop == VALU_SLT;

    always_comb begin
        word_t tmp;
        r_v = '0;
        case (vsew)
            SEW8: begin
                for (int i = 0; i < 4; i++) begin
                    tmp = elem_op(ext_elem({24'b0, a_v.b[i]}, SEW8, opunsigned),
                                  ext_elem({24'b0, b_v.b[i]}, SEW8, opunsigned), valuop);
                    r_v.b[i] = tmp[7:0];
                end
            end
            SEW16: begin
                for (int i = 0; i < 2; i++) begin
                    tmp = elem_op(ext_elem({16'b0, a_v.h[i]}, SEW16, opunsigned),
                                  ext_elem({16'b0, b_v.h[i]}, SEW16, opunsigned), valuop);
                    r_v.h[i] = tmp[15:0];
                end
            end
            default: begin
                r_v.w = elem_op(ext_elem(a_v.w, SEW32, opunsigned),
                                ext_elem(b_v.w, SEW32, opunsigned), valuop);
            end
        endcase
    end

    // compare answer comes from element 0, bit 0 in every view
    always_comb begin
        if (is_cmp) begin
            res = {31'b0, r_v.w[0]};
        end else if (valuop == VALU_REDSUM) begin
            res = opB;
        end else begin
            res = r_v.w;
        end
    end

endmodule

`default_nettype wire

/* rtl/vec_operand_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_operand_sel #(
    parameter int NUM_LANES = 4
) (
    input  logic                                     CLK,
    input  logic                                     rst,
    input  logic                                     ex_valid,
    input  vec_ctrl_pkg::vcontrol_t                  vctrl,
    input  vec_types_pkg::word_t                     rdat1,
    input  vec_types_pkg::word_t                     rdat2,
    input  vec_types_pkg::word_t [NUM_LANES-1:0]     bank_src1,
    input  vec_types_pkg::word_t [NUM_LANES-1:0]     bank_src2,
    input  vec_types_pkg::word_t [NUM_LANES-1:0]     v0_words,
    output logic                                     s1_valid,
    output vec_ctrl_pkg::vcontrol_t                  s1_ctrl,
    output vec_types_pkg::word_t [NUM_LANES-1:0]     opA,
    output vec_types_pkg::word_t [NUM_LANES-1:0]     opB,
    output logic [4*NUM_LANES-1:0]                   s1_v0
);
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    logic [NUM_LANES*32-1:0] v0_flat;
    logic                    imm_sx;
    word_t                   imm_word;
    word_t                   scalar_word;
    word_t [NUM_LANES-1:0]   sel_a;
    word_t [NUM_LANES-1:0]   sel_b;

    // v0 spans the lanes, lane 0 holds the lowest bits
    assign v0_flat = v0_words;

    // compares always take a signed immediate
    assign imm_sx = vctrl.sign_ext || vctrl.valuop == VALU_SEQ ||
                    vctrl.valuop == VALU_SNE || vctrl.valuop == VALU_SLT;

    always_comb begin
        case (vctrl.vsew)
            SEW8:    imm_word = {4{imm_sx ? {{3{vctrl.imm[4]}}, vctrl.imm}
                                          : {3'b0, vctrl.imm}}};
            SEW16:   imm_word = {2{imm_sx ? {{11{vctrl.imm[4]}}, vctrl.imm}
                                          : {11'b0, vctrl.imm}}};
            default: imm_word = imm_sx ? {{27{vctrl.imm[4]}}, vctrl.imm}
                                       : {27'b0, vctrl.imm};
        endcase
    end

    // scalar cut to element width, then widened to a full word
    always_comb begin
        case (vctrl.vsew)
            SEW8:    scalar_word = vctrl.sign_ext ? {{24{rdat1[7]}}, rdat1[7:0]}
                                                  : {24'b0, rdat1[7:0]};
            SEW16:   scalar_word = vctrl.sign_ext ? {{16{rdat1[15]}}, rdat1[15:0]}
                                                  : {16'b0, rdat1[15:0]};
            default: scalar_word = rdat1;
        endcase
    end

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            sel_a[k] = bank_src2[k];
            sel_b[k] = bank_src1[k];
            if (vctrl.use_imm) begin
                sel_b[k] = imm_word;
                // both flags: rs2 stands in for vs2
                if (vctrl.use_scalar) begin
                    sel_a[k] = rdat2;
                end
            end else if (vctrl.use_scalar) begin
                sel_b[k] = scalar_word;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (ex_valid) begin
            s1_ctrl <= vctrl;
            opA     <= sel_a;
            opB     <= sel_b;
            s1_v0   <= v0_flat[4*NUM_LANES-1:0];
        end
    end

endmodule

`default_nettype wire

/* rtl/vec_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_bank #(
    parameter int NUM_VREGS = 8
) (
    input  logic                      CLK,
    input  logic                      rst,
    input  vec_types_pkg::vreg_sel_t  vs1,
    input  vec_types_pkg::vreg_sel_t  vs2,
    input  vec_types_pkg::vreg_sel_t  vw,
    input  logic                      wen,
    input  vec_types_pkg::byte_en_t   byte_wen,
    input  vec_types_pkg::word_t      wdata,
    output vec_types_pkg::word_t      vdat1,
    output vec_types_pkg::word_t      vdat2,
    output vec_types_pkg::word_t      v0
);
    import vec_types_pkg::*;

    word_t [NUM_VREGS-1:0] regs;

    always_ff @(posedge CLK) begin
        if (rst) begin
            regs <= '0;
        end else if (wen) begin
            // only enabled bytes change
            for (int i = 0; i < 4; i++) begin
                if (byte_wen[i]) begin
                    regs[vw][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // reads are combinational, no write bypass
    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];
    assign v0    = regs[0];

endmodule

`default_nettype wire

/* common/vec_ctrl_pkg.sv */
`default_nettype none

package vec_ctrl_pkg;

    typedef enum logic [3:0] {
        VALU_ADD    = 4'd0,
        VALU_SUB    = 4'd1,
        VALU_AND    = 4'd2,
        VALU_OR     = 4'd3,
        VALU_XOR    = 4'd4,
        VALU_MIN    = 4'd5,
        VALU_MAX    = 4'd6,
        VALU_SEQ    = 4'd7,
        VALU_SNE    = 4'd8,
        VALU_SLT    = 4'd9,
        VALU_REDSUM = 4'd10
    } valuop_t;

    // decoded micro-op entering execute
    typedef struct packed {
        valuop_t                valuop;
        logic                   opunsigned;
        vec_types_pkg::vsew_t   vsew;
        vec_types_pkg::vreg_sel_t vs1_sel;
        vec_types_pkg::vreg_sel_t vs2_sel;
        vec_types_pkg::vreg_sel_t vd_sel;
        logic                   use_imm;
        logic                   use_scalar;
        logic [4:0]             imm;
        logic                   sign_ext;
        logic                   mask_en;
        logic [1:0]             uop_num;
    } vcontrol_t;

    // writeback port control, data and byte enables travel per lane
    typedef struct packed {
        logic                     en;
        vec_types_pkg::vreg_sel_t vd;
    } vwb_ctrl_t;

    // control handed to the memory stage
    typedef struct packed {
        vec_types_pkg::vreg_sel_t vd_sel;
        logic [1:0]               uop_num;
        logic [3:0]               lane_mask;
        logic                     is_mask_res;
    } vexmem_ctrl_t;

endpackage

`default_nettype wire

/* common/vec_types_pkg.sv */
`default_nettype none

package vec_types_pkg;

    // one lane of a vector register
    typedef logic [31:0] word_t;

    // element width within a lane word
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } vsew_t;

    // same lane word seen as bytes, halfwords or a full word
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
        word_t            w;
    } elem_word_u;

    // vector register index, v0..v7
    typedef logic [2:0] vreg_sel_t;

    // byte write enables for one lane word
    typedef logic [3:0] byte_en_t;

endpackage

`default_nettype wire
